/* compile.f */
source/spi_pkg.sv
source/spi_cmd_engine.sv
source/spi_wb_bridge.sv
source/spi_wb_top.sv
dv/spi_dev_model.sv
dv/spi_wb_top_asserts.sv
dv/tb_spi_wb_top.sv

/* dv/spi_dev_model.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_dev_model (
  input  wire  rst_n,
  input  wire  sclk,
  input  wire  cs_n,
  input  wire  mosi,
  output logic miso
);

  logic [7:0]  regs [8];
  logic [11:0] shift_in;
  logic [4:0]  bit_cnt;
  logic [7:0]  tx_sr;

  // a frame starts fresh whenever chip select goes inactive
  always @(posedge sclk or posedge cs_n)
  begin
    if (cs_n)
    begin
      bit_cnt  <= '0;
      shift_in <= '0;
    end
    else
    begin
      if (bit_cnt < 5'd12)
        shift_in <= {shift_in[10:0], mosi};
      bit_cnt <= bit_cnt + 5'd1;
    end
  end

  // on the twelfth rise shift_in still lacks the last data bit, which is on mosi
  always @(posedge sclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= 8'(i * 8'h11);
    end
    else if (!cs_n && bit_cnt == 5'd11 && shift_in[10])
      regs[shift_in[9:7]] <= {shift_in[6:0], mosi};
  end

  always @(negedge sclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      miso  <= 1'b0;
      tx_sr <= '0;
    end
    else if (!cs_n && !shift_in[11])
    begin
      if (bit_cnt == 5'd12)
      begin
        miso  <= regs[shift_in[10:8]][7];
        tx_sr <= {regs[shift_in[10:8]][6:0], 1'b0};
      end
      else if (bit_cnt > 5'd12 && bit_cnt < 5'd20)
      begin
        miso  <= tx_sr[7];
        tx_sr <= {tx_sr[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* dv/spi_stimulus.txt */
# columns are op, register address, write data and expected read byte, all but op in hex
# W writes a peripheral register over SPI and R reads one back and compares
R 0 00 00
R 1 00 11
R 2 00 22
R 3 00 33
R 4 00 44
R 5 00 55
R 6 00 66
R 7 00 77
W 3 a5 00
R 3 00 a5
W 5 3c 00
W 6 c3 00
R 5 00 3c
R 6 00 c3
W 2 f0 00
R 0 00 00
R 1 00 11
R 2 00 f0
R 3 00 a5
R 4 00 44
R 5 00 3c
R 6 00 c3
R 7 00 77

/* dv/spi_wb_top_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_wb_top_asserts (
  input wire clk,
  input wire rst_n,
  input wire busy,
  input wire cs_n,
  input wire sclk,
  input wire wb_cyc,
  input wire wb_stb,
  input wire wb_ack
);

  // the engine only selects the peripheral for an accepted command
  cs_idle_when_not_busy: assert property (
    @(posedge clk) disable iff (!rst_n) !busy |-> cs_n
  ) else $error("cs_n is low while the bridge has no command in flight");

  sclk_quiet_when_deselected: assert property (
    @(posedge clk) disable iff (!rst_n) (cs_n && $past(cs_n)) |-> $stable(sclk)
  ) else $error("sclk moved while cs_n was high");

  ack_needs_strobe: assert property (
    @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
  ) else $error("wb_ack seen without an active strobe");

  // one access gets exactly one ack
  ack_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack
  ) else $error("wb_ack held for two cycles");

endmodule

`default_nettype wire

/* dv/tb_spi_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_wb_top;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  spi_pkg::wb_addr_t wb_adr;
  spi_pkg::wb_data_t wb_dat_w;
  spi_pkg::wb_data_t wb_dat_r;
  logic              wb_ack;
  logic              sclk;
  logic              cs_n;
  logic              mosi;
  logic              miso;

  logic [7:0] op_q[$];
  logic [2:0] addr_q[$];
  logic [7:0] data_q[$];
  logic [7:0] expd_q[$];
  logic [7:0] ref_regs [8];

  // a write command is still running on the engine when the next operation starts
  logic engine_busy = 1'b0;

  int cycles     = 0;
  int limit      = 500;
  int err_data   = 0;
  int err_status = 0;
  int err_other  = 0;

  spi_wb_top u_spi_wb_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso)
  );

  spi_dev_model u_dev_model (
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  bind spi_wb_top spi_wb_top_asserts u_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .busy   (u_bridge.busy),
    .cs_n   (cs_n),
    .sclk   (sclk),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("run stopped by timeout after %0d cycles", cycles);
      err_other++;
      report_and_finish();
    end
  end

  task automatic report_and_finish();
    $display("data errors %0d, status errors %0d, other errors %0d",
             err_data, err_status, err_other);
    if (err_data + err_status + err_other == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  task automatic load_stimulus();
    int          fd;
    int          code;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;

    fd = $fopen("dv/spi_stimulus.txt", "r");
    if (fd == 0)
      $display("cannot open dv/spi_stimulus.txt for reading");
    else
    begin
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#")
        begin
          code = $sscanf(line, "%c %h %h %h", op, a, d, e);
          if (code == 4)
          begin
            op_q.push_back(op);
            addr_q.push_back(a[2:0]);
            data_q.push_back(d[7:0]);
            expd_q.push_back(e[7:0]);
          end
          else
          begin
            $display("malformed stimulus line skipped");
            err_other++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_register(input spi_pkg::wb_addr_t addr, input spi_pkg::wb_data_t data,
                                output int waited);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = addr;
    wb_dat_w = data;
    waited   = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end while (!wb_ack);
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_register(input spi_pkg::wb_addr_t addr, output spi_pkg::wb_data_t data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = addr;
    do
      @(negedge clk);
    while (!wb_ack);
    data = wb_dat_r;
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  function automatic spi_pkg::wb_data_t command_word(input logic wr, input logic [2:0] addr,
                                                     input logic [7:0] data);
    spi_pkg::wb_data_t word;

    word = '0;
    word[spi_pkg::cmd_wr_bit] = wr;
    word[10:8] = addr;
    word[7:0] = data;
    return word;
  endfunction

  task automatic store_byte(input logic [2:0] addr, input logic [7:0] data);
    spi_pkg::wb_data_t status;
    int                waited;

    read_register(spi_pkg::reg_status, status);
    if (status[spi_pkg::status_busy_bit] !== engine_busy)
    begin
      $display("ERR wb_dat_r status busy before write got 0x%h exp 0x%h",
               status[spi_pkg::status_busy_bit], engine_busy);
      err_status++;
    end
    write_register(spi_pkg::reg_cmd, command_word(1'b1, addr, data), waited);
    // an idle engine takes the command one cycle after cmd_vld rises
    if (engine_busy)
    begin
      if (waited <= 2)
      begin
        $display("command write to reg %0d was not held off by the busy engine", addr);
        err_other++;
      end
    end
    else if (waited != 2)
    begin
      $display("command write to idle engine took %0d cycles instead of 2", waited);
      err_other++;
    end
    ref_regs[addr] = data;
    engine_busy = 1'b1;
  endtask

  task automatic fetch_byte(input logic [2:0] addr, input logic [7:0] expd);
    spi_pkg::wb_data_t status;
    spi_pkg::wb_data_t rdata;
    int                waited;

    write_register(spi_pkg::reg_cmd, command_word(1'b0, addr, 8'h00), waited);
    status = '0;
    while (!status[spi_pkg::status_rrdy_bit])
      read_register(spi_pkg::reg_status, status);
    if (status !== 32'h0000_0002)
    begin
      $display("ERR wb_dat_r status after read got 0x%08h exp 0x00000002", status);
      err_status++;
    end
    read_register(spi_pkg::reg_rdata, rdata);
    if (rdata !== {24'h0, ref_regs[addr]})
    begin
      $display("ERR wb_dat_r reg %0d got 0x%08h exp 0x%08h", addr, rdata,
               {24'h0, ref_regs[addr]});
      err_data++;
    end
    if (rdata[7:0] !== expd)
    begin
      $display("ERR wb_dat_r reg %0d got 0x%02h stimulus exp 0x%02h", addr, rdata[7:0], expd);
      err_data++;
    end
    // fetching the byte clears read_ready
    read_register(spi_pkg::reg_status, status);
    if (status !== 32'h0)
    begin
      $display("ERR wb_dat_r status after fetch got 0x%08h exp 0x00000000", status);
      err_status++;
    end
    engine_busy = 1'b0;
  endtask

  initial
  begin
    spi_pkg::wb_data_t status;

    rst_n    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    for (int i = 0; i < 8; i++)
      ref_regs[i] = 8'(i * 8'h11);
    load_stimulus();
    limit = op_q.size() * 120 + 500;

    #1 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    if (cs_n !== 1'b1)
    begin
      $display("ERR cs_n after reset got 0x%h exp 0x1", cs_n);
      err_status++;
    end
    if (sclk !== 1'b0)
    begin
      $display("ERR sclk after reset got 0x%h exp 0x0", sclk);
      err_status++;
    end
    if (mosi !== 1'b0)
    begin
      $display("ERR mosi after reset got 0x%h exp 0x0", mosi);
      err_status++;
    end
    if (wb_ack !== 1'b0)
    begin
      $display("ERR wb_ack after reset got 0x%h exp 0x0", wb_ack);
      err_status++;
    end
    read_register(spi_pkg::reg_status, status);
    if (status !== 32'h0)
    begin
      $display("ERR wb_dat_r status after reset got 0x%08h exp 0x00000000", status);
      err_status++;
    end

    if (op_q.size() == 0)
    begin
      $display("no operations were read from the stimulus file");
      err_other++;
    end
    for (int n = 0; n < op_q.size(); n++)
    begin
      if (op_q[n] == "W")
        store_byte(addr_q[n], data_q[n]);
      else if (op_q[n] == "R")
        fetch_byte(addr_q[n], expd_q[n]);
      else
      begin
        $display("unknown operation in stimulus line %0d", n);
        err_other++;
      end
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_spi_wb_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_spi_wb_top > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx '>>> PASS' "$log"; then
  exit 0
fi

echo "pass line not found in $log"
exit 1

/* source/spi_cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_engine (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire spi_pkg::cmd_t     cmd,
  input  wire                    cmd_vld,
  output logic                   cmd_rdy,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  input  wire                    miso,
  output logic                   read_vld,
  output spi_pkg::rdata_t        read_data
);

  spi_pkg::engine_state_t state;
  spi_pkg::engine_state_t state_nxt;
  spi_pkg::div_cnt_t      div_cnt;
  spi_pkg::bit_cnt_t      bit_cnt;
  spi_pkg::cmd_t          cmd_sr;
  spi_pkg::rdata_t        rx_sr;
  logic                   is_wr;
  logic                   accept;
  logic                   half_tick;
  logic                   rise_tick;
  logic                   fall_tick;
  logic                   last_cmd_bit;
  logic                   last_read_bit;

  assign cmd_rdy   = (state == spi_pkg::idle);
  assign accept    = cmd_vld && cmd_rdy;
  assign read_data = rx_sr;

  // divider wraps once per sclk half period
  assign half_tick = (div_cnt == spi_pkg::div_cnt_t'(spi_pkg::sclk_half - 1));
  assign rise_tick = half_tick && !sclk;
  assign fall_tick = half_tick && sclk;

  assign last_cmd_bit  = (bit_cnt == spi_pkg::bit_cnt_t'(spi_pkg::cmd_width - 1));
  assign last_read_bit = (bit_cnt == spi_pkg::bit_cnt_t'(spi_pkg::read_width - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= spi_pkg::idle;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      spi_pkg::idle:
        if (cmd_vld)
          state_nxt = spi_pkg::load;
      spi_pkg::load:
        state_nxt = spi_pkg::shift_cmd;
      spi_pkg::shift_cmd:
        // a write is done after the command bits, a read still has a byte to fetch
        if (fall_tick && last_cmd_bit)
          state_nxt = is_wr ? spi_pkg::finish : spi_pkg::shift_read;
      spi_pkg::shift_read:
        if (fall_tick && last_read_bit)
          state_nxt = spi_pkg::finish;
      spi_pkg::finish:
        if (half_tick)
          state_nxt = spi_pkg::idle;
      default:
        state_nxt = spi_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt  <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
      cs_n     <= 1'b1;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      is_wr    <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        spi_pkg::idle:
        begin
          if (accept)
            is_wr <= cmd[spi_pkg::cmd_wr_bit];
        end
        spi_pkg::load:
        begin
          // cs_n falls half a period ahead of the first rising sclk edge
          cs_n    <= 1'b0;
          mosi    <= cmd_sr[spi_pkg::cmd_width-1];
          div_cnt <= '0;
          bit_cnt <= '0;
        end
        spi_pkg::shift_cmd, spi_pkg::shift_read:
        begin
          if (half_tick)
          begin
            div_cnt <= '0;
            sclk    <= ~sclk;
          end
          else
            div_cnt <= div_cnt + 1'b1;
          // mosi only moves on the falling edge, so it is stable at the next rise
          if (fall_tick)
          begin
            if ((state == spi_pkg::shift_cmd && last_cmd_bit) ||
                (state == spi_pkg::shift_read && last_read_bit))
            begin
              bit_cnt <= '0;
              mosi    <= 1'b0;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (state == spi_pkg::shift_cmd)
                mosi <= cmd_sr[spi_pkg::cmd_width-2];
              else
                mosi <= 1'b0;
            end
          end
        end
        spi_pkg::finish:
        begin
          if (half_tick)
          begin
            div_cnt  <= '0;
            cs_n     <= 1'b1;
            read_vld <= !is_wr;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        default:
        begin
          cs_n <= 1'b1;
          sclk <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_sr <= cmd;
    else if (state == spi_pkg::shift_cmd && fall_tick)
      cmd_sr <= {cmd_sr[spi_pkg::cmd_width-2:0], 1'b0};
    // the peripheral's byte arrives MSB first, sampled on the rising edge
    if (state == spi_pkg::shift_read && rise_tick)
      rx_sr <= {rx_sr[spi_pkg::read_width-2:0], miso};
  end

endmodule

`default_nettype wire

/* source/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  localparam int cmd_width     = 12;
  localparam int read_width    = 8;
  localparam int wb_data_width = 32;
  localparam int wb_addr_width = 4;

  // write flag sits on top of the address and data fields
  localparam int cmd_wr_bit = cmd_width - 1;

  // clk cycles per sclk half period, fixed at build time
  localparam int sclk_half     = 2;
  localparam int div_width     = $clog2(sclk_half + 1);
  localparam int bit_cnt_width = $clog2(cmd_width + 1);

  typedef logic [cmd_width-1:0]     cmd_t;
  typedef logic [read_width-1:0]    rdata_t;
  typedef logic [wb_data_width-1:0] wb_data_t;
  typedef logic [wb_addr_width-1:0] wb_addr_t;
  typedef logic [div_width-1:0]     div_cnt_t;
  typedef logic [bit_cnt_width-1:0] bit_cnt_t;

  // byte addresses seen by the host
  localparam wb_addr_t reg_cmd    = 4'h0;
  localparam wb_addr_t reg_status = 4'h4;
  localparam wb_addr_t reg_rdata  = 4'h8;

  localparam int status_busy_bit = 0;
  localparam int status_rrdy_bit = 1;

  typedef enum logic [2:0] {
    idle,
    load,
    shift_cmd,
    shift_read,
    finish
  } engine_state_t;

endpackage

`default_nettype wire

/* source/spi_wb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_wb_bridge (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire spi_pkg::wb_addr_t   wb_adr,
  input  wire spi_pkg::wb_data_t   wb_dat_w,
  output spi_pkg::wb_data_t        wb_dat_r,
  output logic                     wb_ack,
  output spi_pkg::cmd_t            cmd,
  output logic                     cmd_vld,
  input  wire                      cmd_rdy,
  input  wire                      read_vld,
  input  wire spi_pkg::rdata_t     read_data
);

  logic              req;
  logic              cmd_wr;
  logic              accept;
  logic              rdata_rd;
  logic              busy;
  logic              pend_wr;
  logic              read_ready;
  spi_pkg::rdata_t   rbyte;
  spi_pkg::wb_data_t rd_mux;

  // the ack cycle masks the strobe so one access is never answered twice
  assign req      = wb_cyc && wb_stb && !wb_ack;
  assign cmd_wr   = req && wb_we && (wb_adr == spi_pkg::reg_cmd);
  assign accept   = cmd_vld && cmd_rdy;
  assign rdata_rd = req && !wb_we && (wb_adr == spi_pkg::reg_rdata);

  always_comb
  begin
    rd_mux = '0;
    if (!wb_we)
    begin
      case (wb_adr)
        spi_pkg::reg_status:
        begin
          rd_mux[spi_pkg::status_busy_bit] = busy;
          rd_mux[spi_pkg::status_rrdy_bit] = read_ready;
        end
        spi_pkg::reg_rdata:
          rd_mux[spi_pkg::read_width-1:0] = rbyte;
        default:
          rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack     <= 1'b0;
      cmd_vld    <= 1'b0;
      busy       <= 1'b0;
      pend_wr    <= 1'b0;
      read_ready <= 1'b0;
    end
    else
    begin
      // a command write holds the bus until the engine takes it
      wb_ack <= accept || (req && !cmd_wr);
      if (accept)
        cmd_vld <= 1'b0;
      else if (cmd_wr)
        cmd_vld <= 1'b1;

      if (accept)
      begin
        busy    <= 1'b1;
        pend_wr <= cmd[spi_pkg::cmd_wr_bit];
      end
      else if (busy && (pend_wr ? cmd_rdy : read_vld))
        busy <= 1'b0;

      if (read_vld)
        read_ready <= 1'b1;
      else if (rdata_rd)
        read_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_wr && !cmd_vld)
      cmd <= wb_dat_w[spi_pkg::cmd_width-1:0];
    if (read_vld)
      rbyte <= read_data;
    if (req)
      wb_dat_r <= rd_mux;
  end

endmodule

`default_nettype wire

/* source/spi_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_wb_top (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire spi_pkg::wb_addr_t   wb_adr,
  input  wire spi_pkg::wb_data_t   wb_dat_w,
  output spi_pkg::wb_data_t        wb_dat_r,
  output logic                     wb_ack,
  output logic                     sclk,
  output logic                     cs_n,
  output logic                     mosi,
  input  wire                      miso
);

  spi_pkg::cmd_t   cmd;
  logic            cmd_vld;
  logic            cmd_rdy;
  logic            read_vld;
  spi_pkg::rdata_t read_data;

  spi_wb_bridge u_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_cmd_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire
